// ==== source/mister_pkg.sv ====
package mister_pkg;

    // Full OSD status word as delivered by the HPS
    typedef logic [63:0] status_t;

    // Upper status half, decoded two ways. Bit 38 is shared by both views
    // (rotation option LSB for video, UART enable for the I/O side)
    typedef union packed {
        struct packed {
            logic [15:0] rsvd_hi;     // 63:48
            logic [1:0]  crop_scale;  // 47:46
            logic [3:0]  crop_vopt;   // 45:42
            logic        crop_en;     // 41
            logic        rsvd_40;
            logic [1:0]  rot_opt;     // 39:38
            logic [5:0]  rsvd_lo;     // 37:32
        } video;
        struct packed {
            logic [24:0] rsvd_hi;     // 63:39
            logic        uart_en;     // 38
            logic        db15_en;     // 37
            logic [4:0]  rsvd_lo;     // 36:32
        } io;
    } status_hi_u;

    typedef logic [6:0]         user_port_t;  // Extension port pins
    typedef logic [15:0]        menu_mask_t;  // High bit hides the item
    typedef logic [11:0]        hdmi_dim_t;
    typedef logic [11:0]        crop_size_t;
    typedef logic signed [4:0]  crop_off_t;   // -16..+15 lines
    typedef logic [28:0]        ddr_addr_t;
    typedef logic [7:0]         ddr_burst_t;
    typedef logic [7:0]         ddr_be_t;

    // Crop only applies to a full HD output
    localparam hdmi_dim_t  CROP_HDMI_W = 12'd1920;
    localparam hdmi_dim_t  CROP_HDMI_H = 12'd1080;
    localparam crop_size_t CROP_LINES  = 12'd216;

    // Options 6 and up wrap to negative offsets
    localparam logic [3:0] CROP_OPT_WRAP = 4'd6;
    localparam logic [4:0] CROP_OPT_BIAS = 5'd24;

    // Lower status word layout
    localparam int ST_SCAN_FX_LSB     = 3;
    localparam int ST_SCAN_FX_MSB     = 5;
    localparam int ST_HSIZE_EN        = 19;
    localparam int ST_HSIZE_SCALE_LSB = 20;
    localparam int ST_HSIZE_SCALE_MSB = 23;
    localparam int ST_HVOFF_LSB       = 24;  // hoffset low nibble, voffset high
    localparam int ST_HVOFF_MSB       = 31;

endpackage

// ==== source/osd_ctrl.sv ====
`timescale 1ns/10ps

module osd_ctrl #(
    parameter int ROTATE_MENU = 0  // 1 selects the extended rotate menu item
) (
    input  logic                   clk_sys,
    input  logic                   arst_n,
    input  mister_pkg::status_t    status,
    input  logic                   core_vertical,
    input  logic                   direct_video,
    input  logic                   crop_ok,
    output logic                   hsize_enable,
    output logic [3:0]             hsize_scale,
    output logic [3:0]             hoffset,
    output logic [3:0]             voffset,
    output logic                   uart_en,
    output logic                   db15_en,
    output logic                   crop_en,
    output logic [2:0]             crop_scale,
    output logic [3:0]             crop_vopt,
    output logic [2:0]             scan_fx,
    output logic                   framebuf_flip,
    output mister_pkg::menu_mask_t menu_mask
);
    import mister_pkg::*;

    // Menu item positions in the hide mask
    localparam int MENU_CROP    = 5;
    localparam int MENU_ROT_EXT = 4;
    localparam int MENU_HSIZE   = 2;
    localparam int MENU_ROT     = 1;
    localparam int MENU_DIRECT  = 0;

    status_hi_u status_hi;

    assign status_hi = status[63:32];

    assign scan_fx            = status[ST_SCAN_FX_MSB:ST_SCAN_FX_LSB];  // Scanline effect
    assign hsize_enable       = status[ST_HSIZE_EN];
    assign hsize_scale        = status[ST_HSIZE_SCALE_MSB:ST_HSIZE_SCALE_LSB];
    assign {voffset, hoffset} = status[ST_HVOFF_MSB:ST_HVOFF_LSB];

    assign crop_en    = status_hi.video.crop_en;
    assign crop_vopt  = status_hi.video.crop_vopt;
    assign crop_scale = {1'b0, status_hi.video.crop_scale};
    assign uart_en    = status_hi.io.uart_en;  // Shared by game and cheat UART
    assign db15_en    = status_hi.io.db15_en;

    // Flip request goes to the screen rotator
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            framebuf_flip <= 1'b0;
        end else begin
            framebuf_flip <= (status_hi.video.rot_opt == 2'd2);
        end
    end

    always_comb begin
        menu_mask              = '0;
        menu_mask[MENU_CROP]   = crop_ok;
        menu_mask[MENU_HSIZE]  = ~hsize_enable;
        menu_mask[MENU_DIRECT] = direct_video;
        if (ROTATE_MENU != 0) begin
            menu_mask[MENU_ROT_EXT] = ~core_vertical;  // Shown for vertical games
            menu_mask[MENU_ROT]     = 1'b1;
        end else begin
            menu_mask[MENU_ROT_EXT] = 1'b1;
            menu_mask[MENU_ROT]     = ~core_vertical;
        end
    end

endmodule

// ==== source/user_port_mux.sv ====
`timescale 1ns/10ps

module user_port_mux (
    input  logic                   clk_sys,
    input  logic                   arst_n,
    input  logic                   db15_en,
    input  logic                   uart_en,
    input  mister_pkg::user_port_t user_in,
    input  mister_pkg::user_port_t db15_out,
    input  logic                   cheat_tx,
    input  logic                   game_tx,
    output mister_pkg::user_port_t user_out,
    output logic                   uart_rx
);

    // DB15 adapter has priority over the UART
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            user_out <= '1;
        end else if (db15_en) begin
            user_out <= db15_out;
        end else if (uart_en) begin
            // Game and cheat transmitters share pin 0, idle high
            user_out <= {6'h3f, cheat_tx & game_tx};
        end else begin
            user_out <= '1;  // Port released
        end
    end

    // Idle high when the UART is off
    assign uart_rx = uart_en ? user_in[1] : 1'b1;

endmodule

// ==== source/crop_ctrl.sv ====
`timescale 1ns/10ps

module crop_ctrl (
    input  logic                   clk_sys,
    input  logic                   arst_n,
    input  mister_pkg::hdmi_dim_t  hdmi_width,
    input  mister_pkg::hdmi_dim_t  hdmi_height,
    input  logic [2:0]             scan_fx,
    input  logic                   force_scan2x,
    input  logic                   direct_video,
    input  logic                   rotate_en,
    input  logic                   crop_en,
    input  logic [2:0]             crop_scale,
    input  logic [3:0]             crop_vopt,
    output logic                   crop_ok,
    output mister_pkg::crop_off_t  crop_off,
    output mister_pkg::crop_size_t crop_size
);
    import mister_pkg::*;

    logic       crop_ok_nxt;
    logic [4:0] vopt_x2;
    crop_off_t  crop_off_nxt;

    // Video settings that tolerate a vertical crop
    assign crop_ok_nxt = (hdmi_width == CROP_HDMI_W) && (hdmi_height == CROP_HDMI_H) &&
                         (scan_fx == 3'd0) && !force_scan2x && (crop_scale == 3'd0) &&
                         !direct_video && !rotate_en;

    assign vopt_x2 = {crop_vopt, 1'b0};

    // Two-line steps, upper options map below zero
    assign crop_off_nxt = (crop_vopt < CROP_OPT_WRAP) ? vopt_x2 : (vopt_x2 - CROP_OPT_BIAS);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            crop_ok   <= 1'b0;
            crop_off  <= '0;
            crop_size <= '0;
        end else begin
            crop_ok  <= crop_ok_nxt;
            crop_off <= crop_off_nxt;
            // Uses the registered eligibility, one stage behind
            if (crop_ok && crop_en) begin
                crop_size <= CROP_LINES;
            end else begin
                crop_size <= '0;
            end
        end
    end

endmodule

// ==== source/ddr_arbiter.sv ====
`timescale 1ns/10ps

module ddr_arbiter (
    input  logic                   clk_sys,
    input  logic                   arst_n,
    input  logic                   downloading,
    input  logic                   ddr_busy,
    // Fast ROM loader, read only
    input  mister_pkg::ddr_burst_t ld_burstcnt,
    input  mister_pkg::ddr_addr_t  ld_addr,
    input  logic                   ld_rd,
    output logic                   ld_busy,
    // Screen rotator
    input  mister_pkg::ddr_burst_t rot_burstcnt,
    input  mister_pkg::ddr_addr_t  rot_addr,
    input  logic                   rot_rd,
    input  logic                   rot_we,
    input  mister_pkg::ddr_be_t    rot_be,
    output logic                   rot_busy,
    // DDR3 port
    output mister_pkg::ddr_burst_t ddr_burstcnt,
    output mister_pkg::ddr_addr_t  ddr_addr,
    output logic                   ddr_rd,
    output logic                   ddr_we,
    output mister_pkg::ddr_be_t    ddr_be
);

    localparam logic OWNER_ROT = 1'b0;
    localparam logic OWNER_LD  = 1'b1;

    logic owner;
    logic owner_want;
    logic owner_idle;

    assign owner_want = downloading ? OWNER_LD : OWNER_ROT;

    // Current owner has nothing in flight and the port is free
    assign owner_idle = !ddr_busy && !ddr_rd && !ddr_we;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            owner <= OWNER_ROT;
        end else if ((owner != owner_want) && owner_idle) begin
            owner <= owner_want;
        end
    end

    always_comb begin
        if (owner == OWNER_LD) begin
            ddr_burstcnt = ld_burstcnt;
            ddr_addr     = ld_addr;
            ddr_rd       = ld_rd;
            ddr_we       = 1'b0;  // Loader never writes
            ddr_be       = '1;
        end else begin
            ddr_burstcnt = rot_burstcnt;
            ddr_addr     = rot_addr;
            ddr_rd       = rot_rd;
            ddr_we       = rot_we;
            ddr_be       = rot_be;
        end
    end

    // Non-owner is held off
    assign ld_busy  = (owner == OWNER_LD)  ? ddr_busy : 1'b1;
    assign rot_busy = (owner == OWNER_ROT) ? ddr_busy : 1'b1;

endmodule

// ==== source/mister_glue_top.sv ====
`timescale 1ns/10ps

module mister_glue_top #(
    parameter int ROTATE_MENU = 0
) (
    input  logic                   clk_sys,
    input  logic                   arst_n,
    // OSD
    input  mister_pkg::status_t    status,
    input  logic                   core_vertical,
    input  logic                   direct_video,
    output logic                   hsize_enable,
    output logic [3:0]             hsize_scale,
    output logic [3:0]             hoffset,
    output logic [3:0]             voffset,
    output logic                   framebuf_flip,
    output mister_pkg::menu_mask_t menu_mask,
    output logic                   uart_en,
    output logic                   db15_en,
    // User port
    input  mister_pkg::user_port_t user_in,
    input  mister_pkg::user_port_t db15_out,
    input  logic                   cheat_tx,
    input  logic                   game_tx,
    output mister_pkg::user_port_t user_out,
    output logic                   uart_rx,
    // HDMI crop
    input  mister_pkg::hdmi_dim_t  hdmi_width,
    input  mister_pkg::hdmi_dim_t  hdmi_height,
    input  logic                   force_scan2x,
    input  logic                   rotate_en,
    output logic                   crop_ok,
    output mister_pkg::crop_off_t  crop_off,
    output mister_pkg::crop_size_t crop_size,
    // DDR3
    input  logic                   downloading,
    input  logic                   ddr_busy,
    input  mister_pkg::ddr_burst_t ld_burstcnt,
    input  mister_pkg::ddr_addr_t  ld_addr,
    input  logic                   ld_rd,
    output logic                   ld_busy,
    input  mister_pkg::ddr_burst_t rot_burstcnt,
    input  mister_pkg::ddr_addr_t  rot_addr,
    input  logic                   rot_rd,
    input  logic                   rot_we,
    input  mister_pkg::ddr_be_t    rot_be,
    output logic                   rot_busy,
    output mister_pkg::ddr_burst_t ddr_burstcnt,
    output mister_pkg::ddr_addr_t  ddr_addr,
    output logic                   ddr_rd,
    output logic                   ddr_we,
    output mister_pkg::ddr_be_t    ddr_be
);

    // OSD fields used by the crop logic
    logic       crop_en;
    logic [2:0] crop_scale;
    logic [3:0] crop_vopt;
    logic [2:0] scan_fx;

    osd_ctrl #(
        .ROTATE_MENU (ROTATE_MENU)
    ) u_osd_ctrl (
        .clk_sys       (clk_sys),
        .arst_n        (arst_n),
        .status        (status),
        .core_vertical (core_vertical),
        .direct_video  (direct_video),
        .crop_ok       (crop_ok),
        .hsize_enable  (hsize_enable),
        .hsize_scale   (hsize_scale),
        .hoffset       (hoffset),
        .voffset       (voffset),
        .uart_en       (uart_en),
        .db15_en       (db15_en),
        .crop_en       (crop_en),
        .crop_scale    (crop_scale),
        .crop_vopt     (crop_vopt),
        .scan_fx       (scan_fx),
        .framebuf_flip (framebuf_flip),
        .menu_mask     (menu_mask)
    );

    user_port_mux u_user_port_mux (
        .clk_sys  (clk_sys),
        .arst_n   (arst_n),
        .db15_en  (db15_en),
        .uart_en  (uart_en),
        .user_in  (user_in),
        .db15_out (db15_out),
        .cheat_tx (cheat_tx),
        .game_tx  (game_tx),
        .user_out (user_out),
        .uart_rx  (uart_rx)
    );

    crop_ctrl u_crop_ctrl (
        .clk_sys      (clk_sys),
        .arst_n       (arst_n),
        .hdmi_width   (hdmi_width),
        .hdmi_height  (hdmi_height),
        .scan_fx      (scan_fx),
        .force_scan2x (force_scan2x),
        .direct_video (direct_video),
        .rotate_en    (rotate_en),
        .crop_en      (crop_en),
        .crop_scale   (crop_scale),
        .crop_vopt    (crop_vopt),
        .crop_ok      (crop_ok),
        .crop_off     (crop_off),
        .crop_size    (crop_size)
    );

    ddr_arbiter u_ddr_arbiter (
        .clk_sys      (clk_sys),
        .arst_n       (arst_n),
        .downloading  (downloading),
        .ddr_busy     (ddr_busy),
        .ld_burstcnt  (ld_burstcnt),
        .ld_addr      (ld_addr),
        .ld_rd        (ld_rd),
        .ld_busy      (ld_busy),
        .rot_burstcnt (rot_burstcnt),
        .rot_addr     (rot_addr),
        .rot_rd       (rot_rd),
        .rot_we       (rot_we),
        .rot_be       (rot_be),
        .rot_busy     (rot_busy),
        .ddr_burstcnt (ddr_burstcnt),
        .ddr_addr     (ddr_addr),
        .ddr_rd       (ddr_rd),
        .ddr_we       (ddr_we),
        .ddr_be       (ddr_be)
    );

endmodule

// ==== dv/clk_rst_gen.sv ====
`timescale 1ns/10ps

module clk_rst_gen #(
    parameter real CLK_PERIOD = 100.0,
    parameter int  RST_CYCLES = 4
) (
    output logic clk_sys,
    output logic arst_n
);

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2.0) clk_sys = ~clk_sys;
    end

    // Reset released on a rising edge after the hold time
    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_sys);
        arst_n <= 1'b1;
    end

endmodule

// ==== dv/tb_mister_glue.sv ====
`timescale 1ns/10ps

module tb_mister_glue;
    import mister_pkg::*;

    localparam int ROTATE_MENU = 0;
    localparam int NUM_ROWS    = 6 + 6 + 9 + 16 + 8;
    localparam int CYCLE_LIMIT = NUM_ROWS * 8 + 200;
    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

    typedef struct packed {
        logic       elig;
        logic       hsize;
        logic       dv;
        logic       cv;
        menu_mask_t mask;
    } menu_row_t;
    typedef struct packed {
        logic       db15;
        logic [1:0] rot;
        logic       cheat;
        logic       game;
        logic       rx_pin;
        user_port_t db15_out;
        user_port_t exp_out;
        logic       exp_rx;
        logic       exp_flip;
    } port_row_t;
    typedef struct packed {
        hdmi_dim_t  w;
        hdmi_dim_t  h;
        logic [2:0] scan;
        logic       force2x;
        logic [1:0] cs;
        logic       dv;
        logic       rot_en;
        logic       cen;
        logic       exp_ok;
        crop_size_t exp_size;
    } crop_row_t;
    typedef struct packed {
        logic dl;
        logic busy;
        logic rot_rd;
        logic rot_we;
        logic ld_rd;
        logic exp_ld;
    } ddr_row_t;

    logic clk_sys, arst_n;
    status_t status;
    logic core_vertical, direct_video, hsize_enable, framebuf_flip, uart_en, db15_en;
    logic [3:0] hsize_scale, hoffset, voffset;
    menu_mask_t menu_mask;
    user_port_t user_in, db15_out, user_out;
    logic cheat_tx, game_tx, uart_rx;
    hdmi_dim_t hdmi_width, hdmi_height;
    logic force_scan2x, rotate_en, crop_ok;
    crop_off_t crop_off;
    crop_size_t crop_size;
    logic downloading, ddr_busy, ld_rd, ld_busy, rot_rd, rot_we, rot_busy, ddr_rd, ddr_we;
    ddr_burst_t ld_burstcnt, rot_burstcnt, ddr_burstcnt;
    ddr_addr_t ld_addr, rot_addr, ddr_addr;
    ddr_be_t rot_be, ddr_be;

    logic [31:0] lfsr = 32'h775a_b321;
    int cycles = 0;

    menu_row_t menu_tab [6];
    port_row_t port_tab [6];
    crop_row_t crop_tab [9];
    ddr_row_t  ddr_tab  [8];
    localparam crop_off_t OFF_EXP [16] = '{5'sd0, 5'sd2, 5'sd4, 5'sd6, 5'sd8, 5'sd10,
        -5'sd12, -5'sd10, -5'sd8, -5'sd6, -5'sd4, -5'sd2, 5'sd0, 5'sd2, 5'sd4, 5'sd6};

    clk_rst_gen u_clk_rst_gen (.clk_sys(clk_sys), .arst_n(arst_n));

    mister_glue_top #(.ROTATE_MENU(ROTATE_MENU)) DUT (.*);

    task automatic report_failure();
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_mask(string name, menu_mask_t exp, menu_mask_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_nibble(string name, logic [3:0] exp, logic [3:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_port(string name, user_port_t exp, user_port_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_crop_off(string name, crop_off_t exp, crop_off_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_crop_size(string name, crop_size_t exp, crop_size_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_addr(string name, ddr_addr_t exp, ddr_addr_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_burst(string name, ddr_burst_t exp, ddr_burst_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_be(string name, ddr_be_t exp, ddr_be_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            report_failure();
        end
    endtask

    // Galois LFSR stepped once per bit taken
    task automatic take_bits(input int n, output logic [63:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
        end
    endtask

    // Random background with the fields under test forced
    task automatic drive_status(logic hsize, logic [2:0] scan, logic [1:0] cs, logic cen,
                                logic [3:0] vopt, logic [1:0] rot, logic db15);
        logic [63:0] s;
        take_bits(64, s);
        s[5:3]   = scan;
        s[19]    = hsize;
        s[47:46] = cs;
        s[45:42] = vopt;
        s[41]    = cen;
        s[39:38] = rot;  // Bit 38 doubles as UART enable
        s[37]    = db15;
        status <= s;
    endtask

    task automatic wait_sample(int lat);
        repeat (lat) @(posedge clk_sys);
        @(negedge clk_sys);
    endtask

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            report_failure();
        end
    end

    initial begin
        logic [63:0] rnd;
        ddr_addr_t la;
        ddr_addr_t ra;
        ddr_burst_t lb;
        ddr_burst_t rb;
        ddr_be_t rbe;
        logic own_ld;
        string nm;
        status        = '0;
        core_vertical = 1'b0;
        direct_video  = 1'b0;
        user_in       = '1;
        db15_out      = '0;
        cheat_tx      = 1'b1;
        game_tx       = 1'b1;
        hdmi_width    = 12'd1280;
        hdmi_height   = 12'd720;
        force_scan2x  = 1'b0;
        rotate_en     = 1'b0;
        downloading   = 1'b0;
        ddr_busy      = 1'b0;
        ld_rd         = 1'b0;
        ld_burstcnt   = 8'h10;
        ld_addr       = 29'h0100_0000;
        rot_rd        = 1'b0;
        rot_we        = 1'b0;
        rot_burstcnt  = 8'h01;
        rot_addr      = 29'h0012_3456;
        rot_be        = 8'h0f;

        // elig, hsize, dv, cv, mask (ROTATE_MENU = 0)
        menu_tab = '{'{1'b1, 1'b0, 1'b0, 1'b0, 16'h0036}, '{1'b1, 1'b1, 1'b0, 1'b1, 16'h0030},
                     '{1'b0, 1'b1, 1'b1, 1'b0, 16'h0013}, '{1'b0, 1'b0, 1'b1, 1'b1, 16'h0015},
                     '{1'b0, 1'b0, 1'b0, 1'b0, 16'h0016}, '{1'b1, 1'b1, 1'b0, 1'b0, 16'h0032}};
        // db15, rot, cheat, game, rx pin, db15_out, user_out, uart_rx, flip
        port_tab = '{'{1'b1, 2'b01, 1'b0, 1'b0, 1'b1, 7'h55, 7'h55, 1'b1, 1'b0},
                     '{1'b0, 2'b11, 1'b1, 1'b0, 1'b0, 7'h12, 7'h7e, 1'b0, 1'b0},
                     '{1'b0, 2'b01, 1'b1, 1'b1, 1'b0, 7'h00, 7'h7f, 1'b0, 1'b0},
                     '{1'b0, 2'b10, 1'b0, 1'b0, 1'b0, 7'h33, 7'h7f, 1'b1, 1'b1},
                     '{1'b1, 2'b10, 1'b0, 1'b1, 1'b0, 7'h2a, 7'h2a, 1'b1, 1'b1},
                     '{1'b0, 2'b00, 1'b0, 1'b0, 1'b0, 7'h44, 7'h7f, 1'b1, 1'b0}};
        // w, h, scan, force, cs, dv, rot_en, cen, crop_ok, crop_size
        crop_tab = '{'{12'd1920, 12'd1080, 3'd0, 1'b0, 2'd0, 1'b0, 1'b0, 1'b1, 1'b1, 12'd216},
                     '{12'd1280, 12'd1080, 3'd0, 1'b0, 2'd0, 1'b0, 1'b0, 1'b1, 1'b0, 12'd0},
                     '{12'd1920, 12'd720,  3'd0, 1'b0, 2'd0, 1'b0, 1'b0, 1'b1, 1'b0, 12'd0},
                     '{12'd1920, 12'd1080, 3'd2, 1'b0, 2'd0, 1'b0, 1'b0, 1'b1, 1'b0, 12'd0},
                     '{12'd1920, 12'd1080, 3'd0, 1'b1, 2'd0, 1'b0, 1'b0, 1'b1, 1'b0, 12'd0},
                     '{12'd1920, 12'd1080, 3'd0, 1'b0, 2'd1, 1'b0, 1'b0, 1'b1, 1'b0, 12'd0},
                     '{12'd1920, 12'd1080, 3'd0, 1'b0, 2'd0, 1'b1, 1'b0, 1'b1, 1'b0, 12'd0},
                     '{12'd1920, 12'd1080, 3'd0, 1'b0, 2'd0, 1'b0, 1'b1, 1'b1, 1'b0, 12'd0},
                     '{12'd1920, 12'd1080, 3'd0, 1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 1'b1, 12'd0}};
        // downloading, ddr_busy, rot_rd, rot_we, ld_rd, loader owns afterwards
        ddr_tab = '{'{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0}, '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
                    '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1}, '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1},
                    '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1}, '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1},
                    '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0}, '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0}};

        @(posedge arst_n);
        @(negedge clk_sys);
        check_port("reset user_out", 7'h7f, user_out);
        check_crop_size("reset crop_size", 12'd0, crop_size);
        check_bit("reset framebuf_flip", 1'b0, framebuf_flip);
        check_addr("reset ddr_addr", rot_addr, ddr_addr);
        check_burst("reset ddr_burstcnt", rot_burstcnt, ddr_burstcnt);
        check_be("reset ddr_be", rot_be, ddr_be);
        check_bit("reset rot_busy", 1'b0, rot_busy);
        check_bit("reset ld_busy", 1'b1, ld_busy);

        foreach (menu_tab[i]) begin
            @(posedge clk_sys);
            drive_status(menu_tab[i].hsize, 3'd0, 2'd0, 1'b0, 4'd0, 2'd0, 1'b0);
            hdmi_width    <= menu_tab[i].elig ? 12'd1920 : 12'd1280;
            hdmi_height   <= 12'd1080;
            direct_video  <= menu_tab[i].dv;
            core_vertical <= menu_tab[i].cv;
            wait_sample(1);  // crop_ok is one register away
            nm = $sformatf("menu[%0d]", i);
            check_mask(nm, menu_tab[i].mask, menu_mask);
            check_bit({nm, " hsize_enable"}, menu_tab[i].hsize, hsize_enable);
            check_nibble({nm, " hsize_scale"}, status[23:20], hsize_scale);
            check_nibble({nm, " hoffset"}, status[27:24], hoffset);
            check_nibble({nm, " voffset"}, status[31:28], voffset);
        end

        foreach (port_tab[i]) begin
            @(posedge clk_sys);
            drive_status(1'b0, 3'd0, 2'd0, 1'b0, 4'd0, port_tab[i].rot, port_tab[i].db15);
            take_bits(7, rnd);
            rnd[1] = port_tab[i].rx_pin;
            direct_video <= 1'b0;
            user_in      <= rnd[6:0];
            db15_out     <= port_tab[i].db15_out;
            cheat_tx     <= port_tab[i].cheat;
            game_tx      <= port_tab[i].game;
            wait_sample(1);
            nm = $sformatf("port[%0d]", i);
            check_port({nm, " user_out"}, port_tab[i].exp_out, user_out);
            check_bit({nm, " uart_rx"}, port_tab[i].exp_rx, uart_rx);
            check_bit({nm, " flip"}, port_tab[i].exp_flip, framebuf_flip);
            check_bit({nm, " uart_en"}, port_tab[i].rot[0], uart_en);
            check_bit({nm, " db15_en"}, port_tab[i].db15, db15_en);
        end

        foreach (crop_tab[i]) begin
            @(posedge clk_sys);
            drive_status(1'b0, crop_tab[i].scan, crop_tab[i].cs, crop_tab[i].cen, 4'd1,
                         2'd0, 1'b0);
            hdmi_width   <= crop_tab[i].w;
            hdmi_height  <= crop_tab[i].h;
            force_scan2x <= crop_tab[i].force2x;
            direct_video <= crop_tab[i].dv;
            rotate_en    <= crop_tab[i].rot_en;
            wait_sample(2);
            nm = $sformatf("crop[%0d]", i);
            check_bit({nm, " crop_ok"}, crop_tab[i].exp_ok, crop_ok);
            check_crop_size({nm, " crop_size"}, crop_tab[i].exp_size, crop_size);
            check_crop_off({nm, " crop_off"}, OFF_EXP[1], crop_off);
        end

        for (int v = 0; v < 16; v++) begin
            @(posedge clk_sys);
            drive_status(1'b0, 3'd0, 2'd0, 1'b1, v[3:0], 2'd0, 1'b0);
            hdmi_width   <= 12'd1920;
            hdmi_height  <= 12'd1080;
            force_scan2x <= 1'b0;
            direct_video <= 1'b0;
            rotate_en    <= 1'b0;
            wait_sample(2);
            check_crop_off($sformatf("offset opt %0d", v), OFF_EXP[v], crop_off);
            check_crop_size($sformatf("offset opt %0d size", v), 12'd216, crop_size);
        end

        foreach (ddr_tab[i]) begin
            @(posedge clk_sys);
            take_bits(29, rnd);
            la = rnd[28:0];
            take_bits(29, rnd);
            ra = rnd[28:0];
            take_bits(8, rnd);
            rbe = rnd[7:0];
            lb = 8'(i + 8'h20);
            rb = 8'(i + 8'h40);
            downloading  <= ddr_tab[i].dl;
            ddr_busy     <= ddr_tab[i].busy;
            rot_rd       <= ddr_tab[i].rot_rd;
            rot_we       <= ddr_tab[i].rot_we;
            ld_rd        <= ddr_tab[i].ld_rd;
            ld_addr      <= la;
            rot_addr     <= ra;
            ld_burstcnt  <= lb;
            rot_burstcnt <= rb;
            rot_be       <= rbe;
            wait_sample(1);  // Owner change shows one cycle after an idle cycle
            own_ld = ddr_tab[i].exp_ld;
            nm = $sformatf("ddr[%0d]", i);
            check_addr({nm, " addr"}, own_ld ? la : ra, ddr_addr);
            check_burst({nm, " burst"}, own_ld ? lb : rb, ddr_burstcnt);
            check_bit({nm, " rd"}, own_ld ? ddr_tab[i].ld_rd : ddr_tab[i].rot_rd, ddr_rd);
            check_bit({nm, " we"}, own_ld ? 1'b0 : ddr_tab[i].rot_we, ddr_we);
            check_be({nm, " be"}, own_ld ? 8'hff : rbe, ddr_be);
            check_bit({nm, " rot_busy"}, own_ld ? 1'b1 : ddr_tab[i].busy, rot_busy);
            check_bit({nm, " ld_busy"}, own_ld ? ddr_tab[i].busy : 1'b1, ld_busy);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
source/mister_pkg.sv
source/osd_ctrl.sv
source/user_port_mux.sv
source/crop_ctrl.sv
source/ddr_arbiter.sv
source/mister_glue_top.sv
dv/clk_rst_gen.sv
dv/tb_mister_glue.sv

// ==== Makefile ====
BUILD_DIR := build

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f sim.f --top-module tb_mister_glue \
		-Mdir $(BUILD_DIR) -o Vtb_mister_glue

run: build
	./$(BUILD_DIR)/Vtb_mister_glue

lint:
	verilator --lint-only --timing -f sim.f --top-module tb_mister_glue

clean:
	rm -rf $(BUILD_DIR)
